/* common/conv_pkg.sv */
package conv_pkg;

    // Frame geometry
    localparam int IMG_WIDTH  = 8;
    localparam int IMG_HEIGHT = 6;
    localparam int COL_W      = 3;     // Column index, 0 .. IMG_WIDTH-1

    // Datapath widths
    localparam int PIX_W      = 16;    // Pixels and results
    localparam int WGT_W      = 8;     // Kernel taps
    localparam int ACC_W      = 28;    // Nine full products plus growth

    // Result scaling, arithmetic shift before clipping
    localparam int OUT_SHIFT  = 4;

    typedef logic signed [PIX_W-1:0] pixel_t;
    typedef logic signed [WGT_W-1:0] weight_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [COL_W-1:0]        col_t;

    // Line buffer sequencer
    typedef enum logic [2:0] {
        IDLE,     // Waiting for the first pixel of a frame
        FILL,     // Row 0, nothing above it yet
        RUN,      // Rows 1 and later, windows issued
        EDGE,     // Zero column after each row
        FLUSH     // Zero row after the last one
    } ctrl_state_t;

endpackage

/* line_buffer/line_buffer_ram.sv */
`timescale 1ns/1ps

module line_buffer_ram (
    input  logic             clk,
    input  logic             wr,
    input  conv_pkg::col_t   addr,
    input  conv_pkg::pixel_t wdata,
    output conv_pkg::pixel_t rdata
);

    // One image row
    conv_pkg::pixel_t mem [conv_pkg::IMG_WIDTH];

    // Read-first, so the old row leaves while the new one lands
    always_ff @(posedge clk) begin
        rdata <= mem[addr];          // Read every cycle
        if (wr) begin
            mem[addr] <= wdata;      // Same column address
        end
    end

endmodule

/* line_buffer/window_reg_3x3.sv */
`timescale 1ns/1ps

module window_reg_3x3 (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clr,
    input  logic             shift,
    input  conv_pkg::pixel_t in_row0,   // Top, row n-2
    input  conv_pkg::pixel_t in_row1,   // Middle, row n-1
    input  conv_pkg::pixel_t in_row2,   // Bottom, row n
    output conv_pkg::pixel_t w00,
    output conv_pkg::pixel_t w01,
    output conv_pkg::pixel_t w02,
    output conv_pkg::pixel_t w10,
    output conv_pkg::pixel_t w11,
    output conv_pkg::pixel_t w12,
    output conv_pkg::pixel_t w20,
    output conv_pkg::pixel_t w21,
    output conv_pkg::pixel_t w22
);

    // wRC is row R, column C; column 2 holds the newest sample
    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            w00 <= '0;
            w01 <= '0;
            w02 <= '0;
            w10 <= '0;
            w11 <= '0;
            w12 <= '0;
            w20 <= '0;
            w21 <= '0;
            w22 <= '0;
        end else if (shift) begin
            w00 <= w01;              // Top row moves left
            w01 <= w02;
            w02 <= in_row0;
            w10 <= w11;              // Middle row
            w11 <= w12;
            w12 <= in_row1;
            w20 <= w21;              // Bottom row
            w21 <= w22;
            w22 <= in_row2;
        end
    end

endmodule

/* line_buffer/line_buffer_datapath.sv */
`timescale 1ns/1ps

module line_buffer_datapath (
    input  logic             clk,
    input  logic             rst_n,
    input  conv_pkg::pixel_t pix_data,
    input  logic             col_en,
    input  logic             col_clr,
    input  logic             ram_wr,
    input  logic             win_clr,
    input  logic             win_shift,
    input  logic             row_n_sel,
    input  logic             row_n1_sel,
    input  logic             row_n2_sel,
    output conv_pkg::col_t   col,
    output conv_pkg::pixel_t w00,
    output conv_pkg::pixel_t w01,
    output conv_pkg::pixel_t w02,
    output conv_pkg::pixel_t w10,
    output conv_pkg::pixel_t w11,
    output conv_pkg::pixel_t w12,
    output conv_pkg::pixel_t w20,
    output conv_pkg::pixel_t w21,
    output conv_pkg::pixel_t w22
);

    conv_pkg::pixel_t pix_d;          // Pixel lined up with the memory reads
    conv_pkg::pixel_t lb_n1_rdata;
    conv_pkg::pixel_t lb_n2_rdata;
    conv_pkg::pixel_t row_n;
    conv_pkg::pixel_t row_n1;
    conv_pkg::pixel_t row_n2;

    // Column counter, wraps at the row end
    always_ff @(posedge clk) begin
        if (!rst_n || col_clr) begin
            col <= '0;
        end else if (col_en) begin
            if (col == conv_pkg::col_t'(conv_pkg::IMG_WIDTH - 1)) begin
                col <= '0;
            end else begin
                col <= col + conv_pkg::col_t'(1);
            end
        end
    end

    // Memory output is one cycle late, so is the pixel
    always_ff @(posedge clk) begin
        pix_d <= pix_data;
    end

    // Deasserted select injects a zero sample
    assign row_n  = row_n_sel  ? pix_d       : '0;
    assign row_n1 = row_n1_sel ? lb_n1_rdata : '0;
    assign row_n2 = row_n2_sel ? lb_n2_rdata : '0;

    // Row n-1 store, fed by the current row
    line_buffer_ram u_lb_n1 (
        .clk   (clk),
        .wr    (ram_wr),
        .addr  (col),
        .wdata (row_n),
        .rdata (lb_n1_rdata)
    );

    // Row n-2 store, cascaded from the row n-1 output
    line_buffer_ram u_lb_n2 (
        .clk   (clk),
        .wr    (ram_wr),
        .addr  (col),
        .wdata (row_n1),
        .rdata (lb_n2_rdata)
    );

    window_reg_3x3 u_window (
        .clk     (clk),
        .rst_n   (rst_n),
        .clr     (win_clr),
        .shift   (win_shift),
        .in_row0 (row_n2),            // Oldest row on top
        .in_row1 (row_n1),
        .in_row2 (row_n),
        .w00     (w00),
        .w01     (w01),
        .w02     (w02),
        .w10     (w10),
        .w11     (w11),
        .w12     (w12),
        .w20     (w20),
        .w21     (w21),
        .w22     (w22)
    );

endmodule

/* verilog/line_buffer_ctrl.sv */
`timescale 1ns/1ps

module line_buffer_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pix_valid,
    input  conv_pkg::col_t col,
    output logic           busy,
    output logic           col_en,
    output logic           col_clr,
    output logic           ram_wr,
    output logic           win_clr,
    output logic           win_shift,
    output logic           row_n_sel,
    output logic           row_n1_sel,
    output logic           row_n2_sel,
    output logic           win_valid
);

    typedef logic [$clog2(conv_pkg::IMG_HEIGHT)-1:0] row_t;

    conv_pkg::ctrl_state_t state;
    row_t                  row;         // Incoming row index
    logic                  shift_cyc;   // Second cycle of a pixel, write and shift
    logic                  tail;        // Final zero column of FLUSH
    logic                  accept;
    logic                  in_row;
    logic                  px_step;
    logic                  flush_col;
    logic                  last_col;
    logic                  last_row;    // Bottom row of the frame

    // Each pixel takes two cycles: memory read, then write plus shift
    assign busy      = shift_cyc || (state == conv_pkg::EDGE) || (state == conv_pkg::FLUSH);
    assign accept    = pix_valid && !busy;
    assign in_row    = (state == conv_pkg::FILL) || (state == conv_pkg::RUN);
    assign px_step   = in_row && shift_cyc;
    assign flush_col = (state == conv_pkg::FLUSH) && !tail;   // Memory columns of the flush
    assign last_col  = (col == conv_pkg::col_t'(conv_pkg::IMG_WIDTH - 1));
    assign last_row  = (row == row_t'(conv_pkg::IMG_HEIGHT - 1));

    // Reads are registered, so the flush address runs one column ahead
    assign col_en    = px_step || flush_col || ((state == conv_pkg::EDGE) && last_row);
    assign col_clr   = (state == conv_pkg::IDLE);
    assign ram_wr    = px_step;
    assign win_clr   = (state == conv_pkg::IDLE);
    assign win_shift = px_step || (state == conv_pkg::EDGE) || (state == conv_pkg::FLUSH);

    // Rows not yet present read as zero, EDGE and the tail are all zero
    assign row_n_sel  = in_row;
    assign row_n1_sel = (state == conv_pkg::RUN) || flush_col;
    assign row_n2_sel = ((state == conv_pkg::RUN) && (row > row_t'(1))) || flush_col;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= conv_pkg::IDLE;
            row       <= '0;
            shift_cyc <= 1'b0;
            tail      <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= 1'b0;                          // Single-cycle pulse
            case (state)
                conv_pkg::IDLE: begin
                    row <= '0;
                    if (accept) begin
                        shift_cyc <= 1'b1;
                        state     <= conv_pkg::FILL;
                    end
                end
                conv_pkg::FILL, conv_pkg::RUN: begin
                    if (shift_cyc) begin
                        shift_cyc <= 1'b0;
                        // Centre is one column behind the shifted one
                        win_valid <= (state == conv_pkg::RUN) && (col != '0);
                        if (last_col) begin
                            state <= conv_pkg::EDGE;
                        end
                    end else if (accept) begin
                        shift_cyc <= 1'b1;
                    end
                end
                conv_pkg::EDGE: begin
                    win_valid <= (row != '0);                  // Last centre of row above
                    if (row == row_t'(conv_pkg::IMG_HEIGHT - 1)) begin
                        state <= conv_pkg::FLUSH;
                    end else begin
                        row   <= row + row_t'(1);
                        state <= conv_pkg::RUN;
                    end
                end
                conv_pkg::FLUSH: begin
                    // Address 1 means memory column 0 is the one shifting in
                    win_valid <= tail || (col != conv_pkg::col_t'(1));
                    if (tail) begin
                        tail  <= 1'b0;
                        state <= conv_pkg::IDLE;               // Window cleared there
                    end else if (col == '0) begin              // Column 7 shifting in
                        tail <= 1'b1;
                    end
                end
                default: state <= conv_pkg::IDLE;
            endcase
        end
    end

endmodule

/* verilog/conv3x3_mac.sv */
`timescale 1ns/1ps

module conv3x3_mac (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              w_wr,
    input  logic [3:0]        w_idx,       // 3*row + col in the kernel
    input  conv_pkg::weight_t w_data,
    input  logic              win_valid,
    input  conv_pkg::pixel_t  w00,
    input  conv_pkg::pixel_t  w01,
    input  conv_pkg::pixel_t  w02,
    input  conv_pkg::pixel_t  w10,
    input  conv_pkg::pixel_t  w11,
    input  conv_pkg::pixel_t  w12,
    input  conv_pkg::pixel_t  w20,
    input  conv_pkg::pixel_t  w21,
    input  conv_pkg::pixel_t  w22,
    output logic              out_valid,
    output conv_pkg::pixel_t  out_data
);

    conv_pkg::weight_t wgt [9];
    conv_pkg::pixel_t  win [9];
    conv_pkg::acc_t    prod [9];      // Stage 1
    logic              prod_valid;
    conv_pkg::acc_t    sum;
    conv_pkg::acc_t    shifted;
    conv_pkg::pixel_t  sat;

    assign win = '{w00, w01, w02, w10, w11, w12, w20, w21, w22};   // Raster order

    // Kernel taps, out-of-range index ignored
    always_ff @(posedge clk) begin
        if (w_wr && (w_idx < 4'd9)) begin
            wgt[w_idx] <= w_data;
        end
    end

    // Products, operands widened first
    always_ff @(posedge clk) begin
        for (int k = 0; k < 9; k++) begin
            prod[k] <= conv_pkg::acc_t'(win[k]) * conv_pkg::acc_t'(wgt[k]);
        end
    end

    // Sum, scale and clip to the pixel range
    always_comb begin
        sum = '0;
        for (int k = 0; k < 9; k++) begin
            sum = sum + prod[k];
        end
        shifted = sum >>> conv_pkg::OUT_SHIFT;     // Keeps the sign
        if (shifted > conv_pkg::acc_t'(2 ** (conv_pkg::PIX_W - 1) - 1)) begin
            sat = conv_pkg::pixel_t'(2 ** (conv_pkg::PIX_W - 1) - 1);
        end else if (shifted < conv_pkg::acc_t'(-(2 ** (conv_pkg::PIX_W - 1)))) begin
            sat = conv_pkg::pixel_t'(-(2 ** (conv_pkg::PIX_W - 1)));
        end else begin
            sat = conv_pkg::pixel_t'(shifted);
        end
    end

    always_ff @(posedge clk) begin
        out_data <= sat;                           // Stage 2
    end

    // Valid follows its window through both stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            out_valid  <= prod_valid;
        end
    end

endmodule

/* verilog/conv3x3_top.sv */
`timescale 1ns/1ps

module conv3x3_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pix_valid,
    input  conv_pkg::pixel_t  pix_data,
    input  logic              w_wr,
    input  logic [3:0]        w_idx,
    input  conv_pkg::weight_t w_data,
    output logic              busy,
    output logic              out_valid,
    output conv_pkg::pixel_t  out_data
);

    logic             col_en;
    logic             col_clr;
    logic             ram_wr;
    logic             win_clr;
    logic             win_shift;
    logic             row_n_sel;
    logic             row_n1_sel;
    logic             row_n2_sel;
    logic             win_valid;
    conv_pkg::col_t   col;
    conv_pkg::pixel_t w00, w01, w02;   // Window, top row first
    conv_pkg::pixel_t w10, w11, w12;
    conv_pkg::pixel_t w20, w21, w22;

    line_buffer_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .col        (col),
        .busy       (busy),
        .col_en     (col_en),
        .col_clr    (col_clr),
        .ram_wr     (ram_wr),
        .win_clr    (win_clr),
        .win_shift  (win_shift),
        .row_n_sel  (row_n_sel),
        .row_n1_sel (row_n1_sel),
        .row_n2_sel (row_n2_sel),
        .win_valid  (win_valid)
    );

    line_buffer_datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_data   (pix_data),
        .col_en     (col_en),
        .col_clr    (col_clr),
        .ram_wr     (ram_wr),
        .win_clr    (win_clr),
        .win_shift  (win_shift),
        .row_n_sel  (row_n_sel),
        .row_n1_sel (row_n1_sel),
        .row_n2_sel (row_n2_sel),
        .col        (col),
        .w00        (w00),
        .w01        (w01),
        .w02        (w02),
        .w10        (w10),
        .w11        (w11),
        .w12        (w12),
        .w20        (w20),
        .w21        (w21),
        .w22        (w22)
    );

    conv3x3_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_wr      (w_wr),
        .w_idx     (w_idx),
        .w_data    (w_data),
        .win_valid (win_valid),
        .w00       (w00),
        .w01       (w01),
        .w02       (w02),
        .w10       (w10),
        .w11       (w11),
        .w12       (w12),
        .w20       (w20),
        .w21       (w21),
        .w22       (w22),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

/* dv/conv3x3_tb.sv */
`timescale 1ns/1ps

module conv3x3_tb;

    localparam int W            = conv_pkg::IMG_WIDTH;
    localparam int H            = conv_pkg::IMG_HEIGHT;
    localparam int NPIX         = W * H;
    localparam int FRAME_CYCLES = NPIX + H + W + 1;      // Pixels, edge cycles, flush row
    localparam int NUM_FRAMES   = 5;
    localparam int MAX_CYCLES   = 4 * NUM_FRAMES * FRAME_CYCLES;
    localparam int PIX_MAX      = 2 ** (conv_pkg::PIX_W - 1) - 1;
    localparam int PIX_MIN      = -(2 ** (conv_pkg::PIX_W - 1));

    logic              clk;
    logic              rst_n;
    logic              pix_valid;
    conv_pkg::pixel_t  pix_data;
    logic              w_wr;
    logic [3:0]        w_idx;
    conv_pkg::weight_t w_data;
    logic              busy;
    logic              out_valid;
    conv_pkg::pixel_t  out_data;

    conv_pkg::pixel_t  img [NPIX];      // Current frame, raster order
    conv_pkg::weight_t kern [9];
    conv_pkg::pixel_t  exp_q [$];       // Expected results, oldest first
    logic [31:0]       rng;
    int                cycle_count;
    logic              started;         // First pixel driven

    conv3x3_top u_conv3x3_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .w_wr      (w_wr),
        .w_idx     (w_idx),
        .w_data    (w_data),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Zero-padded 3x3 sum, scaled and clipped
    function automatic conv_pkg::pixel_t conv_ref(input int r, input int c);
        longint acc;
        int     rr;
        int     cc;
        int     dr;
        int     dc;
        acc = 0;
        for (dr = -1; dr <= 1; dr++) begin
            for (dc = -1; dc <= 1; dc++) begin
                rr = r + dr;
                cc = c + dc;
                if (rr >= 0 && rr < H && cc >= 0 && cc < W) begin    // Outside reads as zero
                    acc += longint'(img[rr * W + cc]) * longint'(kern[(dr + 1) * 3 + dc + 1]);
                end
            end
        end
        acc = acc >>> conv_pkg::OUT_SHIFT;
        if (acc > PIX_MAX) begin
            return conv_pkg::pixel_t'(PIX_MAX);
        end else if (acc < PIX_MIN) begin
            return conv_pkg::pixel_t'(PIX_MIN);
        end
        return conv_pkg::pixel_t'(acc);
    endfunction

    task automatic push_model();
        for (int k = 0; k < NPIX; k++) begin
            exp_q.push_back(conv_ref(k / W, k % W));
        end
    endtask

    // Random pixels, sh narrows the range
    task automatic fill_random(input int sh);
        for (int k = 0; k < NPIX; k++) begin
            rng    = xorshift32(rng);
            img[k] = conv_pkg::pixel_t'(rng[15:0]) >>> sh;
        end
    endtask

    task automatic load_kernel();
        for (int k = 0; k < 9; k++) begin
            @(negedge clk);
            w_wr   = 1'b1;
            w_idx  = 4'(k);
            w_data = kern[k];
        end
        @(negedge clk);
        w_wr = 1'b0;
    endtask

    // One pixel per non-busy cycle
    task automatic send_frame();
        int k;
        k = 0;
        while (k < NPIX) begin
            @(negedge clk);
            if (!busy) begin
                pix_valid = 1'b1;
                pix_data  = img[k];
                started   = 1'b1;
                k++;
            end else begin
                pix_valid = 1'b0;
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    // Busy falls after the flush row, then the last window crosses the MAC
    task automatic wait_drain();
        while (busy) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);           // Valid cycle plus two MAC stages
        assert (exp_q.size() == 0)
        else stop_on_error($sformatf("%0d expected results never came out", exp_q.size()));
    endtask

    // Quiet outputs between reset and the first pixel
    always @(negedge clk) begin
        if (rst_n && !started) begin
            assert (!busy && !out_valid)
            else stop_on_error("busy or out_valid went high before any pixel was sent");
        end
    end

    // Results in raster order against the model
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            assert (exp_q.size() > 0)
            else stop_on_error("out_valid pulsed with no expected result left");
            assert (out_data === exp_q[0])
            else stop_on_error($sformatf("[FAIL] %0t out_data got %0d expected %0d",
                                         $time, out_data, exp_q[0]));
            void'(exp_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < MAX_CYCLES)
        else stop_on_error("Timeout, the run went past its cycle limit");
    end

    initial begin
        rst_n       = 1'b0;
        pix_valid   = 1'b0;
        pix_data    = '0;
        w_wr        = 1'b0;
        w_idx       = '0;
        w_data      = '0;
        rng         = 32'h19f2;
        cycle_count = 0;
        started     = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);           // Idle after reset

        // Identity kernel, output is the pixel itself
        foreach (kern[k]) kern[k] = '0;
        kern[4] = 8'sd16;
        load_kernel();
        fill_random(0);
        foreach (img[k]) exp_q.push_back(img[k]);
        send_frame();
        wait_drain();

        // All ones, borders see fewer neighbours
        foreach (kern[k]) kern[k] = 8'sd1;
        load_kernel();
        fill_random(6);
        push_model();
        send_frame();
        wait_drain();

        // Random kernel, two frames back to back
        foreach (kern[k]) begin
            rng     = xorshift32(rng);
            kern[k] = conv_pkg::weight_t'(rng[7:0]);
        end
        load_kernel();
        fill_random(6);
        push_model();
        send_frame();
        fill_random(6);
        push_model();
        send_frame();
        wait_drain();

        // Upper half at the top limit, lower half at the bottom
        foreach (kern[k]) kern[k] = 8'sd127;
        load_kernel();
        foreach (img[k]) begin
            img[k] = (k < NPIX / 2) ? conv_pkg::pixel_t'(PIX_MAX) : conv_pkg::pixel_t'(PIX_MIN);
        end
        push_model();
        send_frame();
        wait_drain();

        $display("No errors");
        $finish;
    end

endmodule

/* sources.f */
common/conv_pkg.sv
line_buffer/line_buffer_ram.sv
line_buffer/window_reg_3x3.sv
line_buffer/line_buffer_datapath.sv
verilog/line_buffer_ctrl.sv
verilog/conv3x3_mac.sv
verilog/conv3x3_top.sv
dv/conv3x3_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module conv3x3_tb -o conv3x3_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/conv3x3_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
